// File: design/rv_pkg.sv
// rv_pkg
// Shared types and constants for the RV32I decode/execute slice.
// Holds the ALU and operand-select encodings, the instruction-format
// views and the packet that travels through the dispatch queue.

package rv_pkg;

    localparam int XLEN = 32;

    // opcodes of the kept instruction classes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [6:0]  F7_BASE  = 7'b0000000;
    localparam logic [6:0]  F7_ALT   = 7'b0100000;  // sub / sra
    localparam logic [31:0] WFI_WORD = 32'h1050_0073;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_SLT  = 4'h2,
        ALU_SLTU = 4'h3,
        ALU_AND  = 4'h4,
        ALU_OR   = 4'h5,
        ALU_XOR  = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_PC   = 2'h1,
        OPA_IS_ZERO = 2'h2
    } opa_sel_t;

    // immediate already resolved by decode, so one imm choice is enough
    typedef enum logic {
        OPB_IS_RS2 = 1'b0,
        OPB_IS_IMM = 1'b1
    } opb_sel_t;

    ////////////////////////////////////////////////////////////////////////////
    // instruction format views
    ////////////////////////////////////////////////////////////////////////////
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic            has_dest;
        opa_sel_t        opa_select;
        opb_sel_t        opb_select;
        alu_func_t       alu_func;
        logic [XLEN-1:0] imm;
        logic            halt;
    } dispatch_pkt_t;

endpackage

// File: design/dispatch_if.sv
// dispatch_if
// Push and pop sides of the dispatch queue between decode and execute.

`timescale 1ns/100ps

interface dispatch_if;

    logic                  push;         // one-cycle strobe from decode
    rv_pkg::dispatch_pkt_t push_pkt;
    logic                  almost_full;  // at most one free slot
    logic                  pop;          // only while empty is low
    rv_pkg::dispatch_pkt_t pop_pkt;      // head entry, combinational
    logic                  empty;

    modport producer (output push, push_pkt, input almost_full);

    modport queue (input push, push_pkt, pop, output almost_full, pop_pkt, empty);

    modport consumer (output pop, input pop_pkt, empty);

endinterface

// File: design/rv_decode.sv
// rv_decode
// Instruction decode for the kept RV32I subset. Matches opcode, funct3
// and funct7, resolves the immediate and registers one dispatch packet,
// which is pushed into the queue on the following edge. Illegal words
// raise a one-cycle flag and are dropped.

`timescale 1ns/100ps

module rv_decode (
    input  logic          clock,
    input  logic          arst_n,
    input  logic          inst_valid,
    input  rv_pkg::inst_t inst,
    input  logic [31:0]   pc,
    output logic          illegal,
    dispatch_if.producer  dq
);

    rv_pkg::dispatch_pkt_t dec_pkt;
    logic                  dec_illegal;
    logic                  accept;
    rv_pkg::dispatch_pkt_t pkt_q;
    logic                  push_q;
    logic                  illegal_q;

    assign accept = inst_valid & ~dq.almost_full;

    ////////////////////////////////////////////////////////////////////////////
    // field decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        // defaults form a nop
        dec_pkt            = '0;
        dec_pkt.pc         = pc;
        dec_pkt.rs1        = inst.r.rs1;
        dec_pkt.rs2        = inst.r.rs2;
        dec_pkt.rd         = inst.r.rd;
        dec_pkt.opa_select = rv_pkg::OPA_IS_RS1;
        dec_pkt.opb_select = rv_pkg::OPB_IS_RS2;
        dec_pkt.alu_func   = rv_pkg::ALU_ADD;
        dec_illegal        = 1'b0;

        case (inst.r.opcode)
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: begin
                dec_pkt.has_dest   = 1'b1;
                dec_pkt.opa_select = (inst.r.opcode == rv_pkg::OPC_LUI) ?
                                     rv_pkg::OPA_IS_ZERO : rv_pkg::OPA_IS_PC;
                dec_pkt.opb_select = rv_pkg::OPB_IS_IMM;
                dec_pkt.imm        = {inst.u.imm, 12'h000};   // upper imm
            end
            rv_pkg::OPC_OP_IMM: begin
                dec_pkt.has_dest   = 1'b1;
                dec_pkt.opb_select = rv_pkg::OPB_IS_IMM;
                dec_pkt.imm        = {{20{inst.i.imm[11]}}, inst.i.imm};
                case (inst.r.funct3)
                    3'b000: dec_pkt.alu_func = rv_pkg::ALU_ADD;
                    3'b010: dec_pkt.alu_func = rv_pkg::ALU_SLT;
                    3'b011: dec_pkt.alu_func = rv_pkg::ALU_SLTU;
                    3'b100: dec_pkt.alu_func = rv_pkg::ALU_XOR;
                    3'b110: dec_pkt.alu_func = rv_pkg::ALU_OR;
                    3'b111: dec_pkt.alu_func = rv_pkg::ALU_AND;
                    3'b001: begin
                        dec_pkt.alu_func = rv_pkg::ALU_SLL;
                        dec_pkt.imm      = {27'b0, inst.i.imm[4:0]};   // shamt
                        dec_illegal      = (inst.r.funct7 != rv_pkg::F7_BASE);
                    end
                    default: begin                                    // srli / srai
                        dec_pkt.imm = {27'b0, inst.i.imm[4:0]};
                        if (inst.r.funct7 == rv_pkg::F7_BASE)
                            dec_pkt.alu_func = rv_pkg::ALU_SRL;
                        else if (inst.r.funct7 == rv_pkg::F7_ALT)
                            dec_pkt.alu_func = rv_pkg::ALU_SRA;
                        else
                            dec_illegal = 1'b1;
                    end
                endcase
            end
            rv_pkg::OPC_OP: begin
                dec_pkt.has_dest = 1'b1;
                if (inst.r.funct7 == rv_pkg::F7_BASE) begin
                    case (inst.r.funct3)
                        3'b000:  dec_pkt.alu_func = rv_pkg::ALU_ADD;
                        3'b001:  dec_pkt.alu_func = rv_pkg::ALU_SLL;
                        3'b010:  dec_pkt.alu_func = rv_pkg::ALU_SLT;
                        3'b011:  dec_pkt.alu_func = rv_pkg::ALU_SLTU;
                        3'b100:  dec_pkt.alu_func = rv_pkg::ALU_XOR;
                        3'b101:  dec_pkt.alu_func = rv_pkg::ALU_SRL;
                        3'b110:  dec_pkt.alu_func = rv_pkg::ALU_OR;
                        default: dec_pkt.alu_func = rv_pkg::ALU_AND;
                    endcase
                end else if (inst.r.funct7 == rv_pkg::F7_ALT && inst.r.funct3 == 3'b000) begin
                    dec_pkt.alu_func = rv_pkg::ALU_SUB;
                end else if (inst.r.funct7 == rv_pkg::F7_ALT && inst.r.funct3 == 3'b101) begin
                    dec_pkt.alu_func = rv_pkg::ALU_SRA;
                end else begin
                    dec_illegal = 1'b1;   // mul/div and friends land here
                end
            end
            rv_pkg::OPC_SYSTEM: begin
                if (inst == rv_pkg::WFI_WORD)
                    dec_pkt.halt = 1'b1;
                else
                    dec_illegal = 1'b1;   // csr ops not supported
            end
            default: dec_illegal = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            push_q    <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            push_q    <= accept & ~dec_illegal;
            illegal_q <= accept & dec_illegal;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) pkt_q <= dec_pkt;
    end

    assign dq.push     = push_q;
    assign dq.push_pkt = pkt_q;
    assign illegal     = illegal_q;

    // a stalled word is held by the source until decode takes it
    a_hold_on_stall: assert property (@(posedge clock) disable iff (!arst_n)
        inst_valid && dq.almost_full |=> $stable(inst) && $stable(pc));

endmodule

// File: design/dispatch_fifo.sv
// dispatch_fifo
// Circular queue of dispatch packets between decode and execute.
// DEPTH must be a power of two; pointers wrap on their own.

`timescale 1ns/100ps

module dispatch_fifo #(
    parameter int DEPTH = 8
) (
    input  logic      clock,
    input  logic      arst_n,
    dispatch_if.queue dq
);

    localparam int           AW         = $clog2(DEPTH);
    localparam logic [AW:0]  FULL_LEVEL = (AW+1)'(DEPTH);
    localparam logic [AW:0]  AF_LEVEL   = (AW+1)'(DEPTH - 1);

    rv_pkg::dispatch_pkt_t mem [DEPTH];
    logic [AW-1:0]         wr_ptr;
    logic [AW-1:0]         rd_ptr;
    logic [AW:0]           count;

    always_ff @(posedge clock) begin
        if (dq.push) mem[wr_ptr] <= dq.push_pkt;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (dq.push) wr_ptr <= wr_ptr + 1'b1;
            if (dq.pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({dq.push, dq.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    assign dq.empty       = (count == '0);
    assign dq.almost_full = (count >= AF_LEVEL);   // room for the decode register
    assign dq.pop_pkt     = mem[rd_ptr];

    a_no_push_full: assert property (@(posedge clock) disable iff (!arst_n)
        dq.push |-> count != FULL_LEVEL);

    a_no_pop_empty: assert property (@(posedge clock) disable iff (!arst_n)
        dq.pop |-> !dq.empty);

endmodule

// File: design/rv_execute.sv
// rv_execute
// In-order execute stage. Pops the head packet, reads rs1/rs2 from the
// architectural register file, runs the ALU and writes rd back.
// The writeback is also registered out for reporting. A halt packet
// stops all further pops.

`timescale 1ns/100ps

module rv_execute (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    ex_hold,
    output logic                    wb_valid,
    output logic [4:0]              wb_rd,
    output logic [rv_pkg::XLEN-1:0] wb_data,
    output logic                    halted,
    dispatch_if.consumer            dq
);

    rv_pkg::dispatch_pkt_t   pkt;
    logic [rv_pkg::XLEN-1:0] regs [32];
    logic [rv_pkg::XLEN-1:0] rs1_val;
    logic [rv_pkg::XLEN-1:0] rs2_val;
    logic [rv_pkg::XLEN-1:0] opa;
    logic [rv_pkg::XLEN-1:0] opb;
    logic [rv_pkg::XLEN-1:0] result;
    logic [4:0]              shamt;

    assign pkt    = dq.pop_pkt;
    assign dq.pop = ~dq.empty & ~ex_hold & ~halted;

    // x0 reads as zero
    assign rs1_val = (pkt.rs1 == 5'd0) ? '0 : regs[pkt.rs1];
    assign rs2_val = (pkt.rs2 == 5'd0) ? '0 : regs[pkt.rs2];

    ////////////////////////////////////////////////////////////////////////////
    // operand select and ALU
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (pkt.opa_select)
            rv_pkg::OPA_IS_RS1: opa = rs1_val;
            rv_pkg::OPA_IS_PC:  opa = pkt.pc;
            default:            opa = '0;     // lui
        endcase
    end

    assign opb   = (pkt.opb_select == rv_pkg::OPB_IS_IMM) ? pkt.imm : rs2_val;
    assign shamt = opb[4:0];

    always_comb begin
        case (pkt.alu_func)
            rv_pkg::ALU_SUB:  result = opa - opb;
            rv_pkg::ALU_SLT:  result = {31'b0, $signed(opa) < $signed(opb)};
            rv_pkg::ALU_SLTU: result = {31'b0, opa < opb};
            rv_pkg::ALU_AND:  result = opa & opb;
            rv_pkg::ALU_OR:   result = opa | opb;
            rv_pkg::ALU_XOR:  result = opa ^ opb;
            rv_pkg::ALU_SLL:  result = opa << shamt;
            rv_pkg::ALU_SRL:  result = opa >> shamt;
            rv_pkg::ALU_SRA:  result = $unsigned($signed(opa) >>> shamt);
            default:          result = opa + opb;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // register file and writeback
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (dq.pop && pkt.has_dest && pkt.rd != 5'd0) begin
            regs[pkt.rd] <= result;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            wb_valid <= dq.pop & pkt.has_dest;
            if (dq.pop && pkt.halt) halted <= 1'b1;   // sticky until reset
        end
    end

    always_ff @(posedge clock) begin
        if (dq.pop) begin
            wb_rd   <= pkt.rd;
            wb_data <= result;
        end
    end

    // nothing retires once the halt has been seen
    a_quiet_after_halt: assert property (@(posedge clock) disable iff (!arst_n)
        halted |-> !wb_valid);

endmodule

// File: design/rv_id_ex.sv
// rv_id_ex
// Decode/execute slice of an in-order RV32I pipeline. Decode feeds a
// dispatch queue which execute drains in order.

`timescale 1ns/100ps

module rv_id_ex #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic        clock,
    input  logic        arst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic        ex_hold,
    output logic        inst_stall,
    output logic        illegal,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data,
    output logic        halted
);

    dispatch_if dq ();

    assign inst_stall = dq.almost_full;   // source holds its word while high

    rv_decode u_decode (
        .clock      (clock),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .illegal    (illegal),
        .dq         (dq.producer)
    );

    dispatch_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
        .clock  (clock),
        .arst_n (arst_n),
        .dq     (dq.queue)
    );

    rv_execute u_execute (
        .clock    (clock),
        .arst_n   (arst_n),
        .ex_hold  (ex_hold),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .halted   (halted),
        .dq       (dq.consumer)
    );

endmodule

// File: dv/tb_rv_id_ex.sv
// tb_rv_id_ex
// Random-stimulus testbench for the decode/execute slice. A model
// executes each accepted instruction in order and queues the expected
// writebacks, which are then matched against wb_valid, wb_rd and wb_data.

`timescale 1ns/100ps

module tb_rv_id_ex;

    localparam int          N_INST      = 400;
    localparam int          CLK_PERIOD  = 20;
    localparam int          WATCHDOG_NS = N_INST * 40 * CLK_PERIOD;
    localparam int          SEED        = 15051;
    localparam logic [31:0] PC_BASE     = 32'h0000_1000;
    localparam logic [31:0] WFI         = 32'h1050_0073;

    logic        clock = 1'b0;
    logic        arst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        ex_hold;
    logic        inst_stall;
    logic        illegal;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        halted;

    logic [31:0] prog [N_INST];
    logic [31:0] mrf [32];          // model register file
    logic [36:0] exp_q [$];         // {rd, data} in retire order
    logic        illegal_exp = 1'b0;
    logic        was_halted = 1'b0;
    logic        hold_burst = 1'b0;
    int          idx = 0;
    int          tail = 0;
    int          stall_cycles = 0;
    int          err_wb = 0;
    int          err_illegal = 0;
    int          err_misc = 0;

    rv_id_ex #(.FIFO_DEPTH(8)) uut (
        .clock      (clock),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .ex_hold    (ex_hold),
        .inst_stall (inst_stall),
        .illegal    (illegal),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .halted     (halted)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // stimulus generation
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [4:0] pick_reg();
        if ($urandom_range(0, 9) < 8) return 5'($urandom_range(0, 7));   // dense deps
        return 5'($urandom_range(0, 31));
    endfunction

    function automatic logic [31:0] random_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int unsigned kind;
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        f3   = 3'($urandom_range(0, 7));
        f7   = $urandom_range(0, 1) ? 7'b0100000 : 7'b0000000;
        imm  = 12'($urandom);
        kind = $urandom_range(0, 99);
        if (kind < 8) begin
            case ($urandom_range(0, 2))
                0: return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};   // store
                1: return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b1100011};   // branch
                default: return {7'b0000001, rs2, rs1, f3, rd, 7'b0110011};  // mul
            endcase
        end
        if (kind < 16) return {20'($urandom), rd, 7'b0110111};   // lui
        if (kind < 22) return {20'($urandom), rd, 7'b0010111};   // auipc
        if (kind < 60) begin
            if (f3 == 3'b001) return {7'b0000000, imm[4:0], rs1, f3, rd, 7'b0010011};
            if (f3 == 3'b101) return {f7, imm[4:0], rs1, f3, rd, 7'b0010011};
            return {imm, rs1, f3, rd, 7'b0010011};
        end
        if (f3 != 3'b000 && f3 != 3'b101) f7 = 7'b0000000;   // only add/srl have alt forms
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////
    task automatic model_accept(input logic [31:0] w, input logic [31:0] ipc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [4:0]  sh;
        logic        bad;
        logic        dest;
        a    = mrf[w[19:15]];
        b    = mrf[w[24:20]];
        imm  = {{20{w[31]}}, w[31:20]};
        sh   = w[24:20];
        res  = '0;
        bad  = 1'b0;
        dest = 1'b1;
        case (w[6:0])
            7'b0110111: res = {w[31:12], 12'h000};
            7'b0010111: res = ipc + {w[31:12], 12'h000};
            7'b0010011: begin
                case (w[14:12])
                    3'd0: res = a + imm;
                    3'd1: begin
                        res = a << sh;
                        bad = (w[31:25] != 7'h00);
                    end
                    3'd2: res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                    3'd3: res = (a < imm) ? 32'd1 : 32'd0;
                    3'd4: res = a ^ imm;
                    3'd5: begin
                        if (w[31:25] == 7'h00) res = a >> sh;
                        else if (w[31:25] == 7'h20) res = $signed(a) >>> sh;
                        else bad = 1'b1;
                    end
                    3'd6: res = a | imm;
                    default: res = a & imm;
                endcase
            end
            7'b0110011: begin
                if (w[31:25] == 7'h00) begin
                    case (w[14:12])
                        3'd0: res = a + b;
                        3'd1: res = a << b[4:0];
                        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd3: res = (a < b) ? 32'd1 : 32'd0;
                        3'd4: res = a ^ b;
                        3'd5: res = a >> b[4:0];
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end else if (w[31:25] == 7'h20 && w[14:12] == 3'd0) begin
                    res = a - b;
                end else if (w[31:25] == 7'h20 && w[14:12] == 3'd5) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    bad = 1'b1;
                end
            end
            7'b1110011: begin
                dest = 1'b0;                  // wfi has no destination
                bad  = (w != WFI);
            end
            default: bad = 1'b1;
        endcase
        illegal_exp = bad;
        if (!bad && dest) begin
            exp_q.push_back({w[11:7], res});  // x0 write still reported
            if (w[11:7] != 5'd0) mrf[w[11:7]] = res;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output checks, sampled at the rising edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_outputs();
        logic [36:0] want;
        assert (illegal == illegal_exp) else begin
            err_illegal++;
            $display("Error illegal exp 0x%0h got 0x%0h", illegal_exp, illegal);
        end
        if (wb_valid) begin
            assert (exp_q.size() > 0) else begin
                err_misc++;
                $display("writeback to x%0d arrived with no instruction outstanding", wb_rd);
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                assert (wb_rd == want[36:32]) else begin
                    err_wb++;
                    $display("Error wb_rd exp 0x%0h got 0x%0h", want[36:32], wb_rd);
                end
                assert (wb_data == want[31:0]) else begin
                    err_wb++;
                    $display("Error wb_data exp 0x%08h got 0x%08h", want[31:0], wb_data);
                end
            end
        end
        assert (!(was_halted && wb_valid)) else begin
            err_misc++;
            $display("a writeback was reported after the core halted");
        end
        assert (!(was_halted && !halted)) else begin
            err_misc++;
            $display("halted dropped while the core should stay halted");
        end
        was_halted = halted;
        if (inst_stall) stall_cycles++;
    endtask

    initial begin
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        ex_hold    = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < 32; i++) mrf[i] = '0;
        for (int i = 0; i < N_INST - 1; i++) prog[i] = random_inst();
        prog[N_INST-1] = WFI;
        repeat (10) @(posedge clock);
        #2 arst_n = 1'b1;

        while (tail < 20) begin
            @(posedge clock);
            check_outputs();
            illegal_exp = 1'b0;
            if (inst_valid && !inst_stall) begin
                model_accept(prog[idx], pc);
                idx++;
            end
            if (halted && idx == N_INST) tail++;
            #2;
            if (idx < N_INST) begin   // word held until accepted
                inst_valid = ($urandom_range(0, 3) != 0);
                inst       = prog[idx];
                pc         = PC_BASE + 32'(4 * idx);
            end else begin
                inst_valid = 1'b0;
            end
            if ($urandom_range(0, 59) == 0) hold_burst = ~hold_burst;
            ex_hold = hold_burst ? ($urandom_range(0, 9) != 0) : ($urandom_range(0, 3) == 0);
        end

        assert (exp_q.size() == 0) else begin
            err_misc++;
            $display("%0d expected writebacks never arrived", exp_q.size());
        end
        assert (stall_cycles > 0) else begin
            err_misc++;
            $display("inst_stall never rose during the hold stretches");
        end
        $display("errors: writeback %0d illegal %0d other %0d", err_wb, err_illegal, err_misc);
        if (err_wb + err_illegal + err_misc == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the core halted and drained");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: rv_id_ex.f
design/rv_pkg.sv
design/dispatch_if.sv
design/rv_decode.sv
design/dispatch_fifo.sv
design/rv_execute.sv
design/rv_id_ex.sv
dv/tb_rv_id_ex.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_rv_id_ex
FILELIST   := rv_id_ex.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation PASSED

SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
